// File: design/spi_reg_settings.svh
`ifndef SPI_REG_SETTINGS_SVH
`define SPI_REG_SETTINGS_SVH

// Register address width
`define SPI_ADDR_BITS 3

// One byte register per address
`define SPI_REG_COUNT (1 << `SPI_ADDR_BITS)

// Flops in the SCLK and MOSI synchronizer chains, at least 2
`define SPI_SYNC_STAGES 2

`endif

// File: design/spi_reg_pkg.sv
`include "spi_reg_settings.svh"

package spi_reg_pkg;

	// Frame state of the transfer controller
	typedef enum logic [1:0] {
		st_idle  = 2'b00,	// Waiting for the command byte
		st_read  = 2'b01,	// Shifting register data out on MISO
		st_write = 2'b10	// Waiting for and storing the data byte
	} frame_state_e;

	// Layout of the command byte, MSB first
	typedef struct packed {
		logic                          rw;	// 1 = read, 0 = write
		logic [6-`SPI_ADDR_BITS:0]     unused;	// Don't care
		logic [`SPI_ADDR_BITS-1:0]     addr;
	} spi_cmd_t;

	// A received byte is a command in the first slot and plain data after it
	typedef union packed {
		spi_cmd_t   cmd;
		logic [7:0] data;
	} spi_byte_u;

endpackage

// File: design/spi_link_if.sv
interface spi_link_if
	import spi_reg_pkg::*;
	();

	logic      sclk_rise;	// One clk pulse per SCLK rising edge
	logic      sclk_fall;	// One clk pulse per SCLK falling edge
	logic      byte_done;	// With the falling edge that ends a byte
	spi_byte_u rx_byte;	// Last completed byte

	modport rx (
		output sclk_rise, sclk_fall, byte_done, rx_byte
	);

	modport ctrl (
		input  sclk_rise, sclk_fall, byte_done, rx_byte
	);

endinterface

// File: design/reg_bus_if.sv
`include "spi_reg_settings.svh"

interface reg_bus_if;

	logic [`SPI_ADDR_BITS-1:0] addr;	// Register select
	logic [7:0]                wdata;
	logic                      wr_en;	// Single cycle write strobe
	logic [7:0]                rdata;	// Combinational from addr

	modport master (
		output addr, wdata, wr_en,
		input  rdata
	);

	modport slave (
		input  addr, wdata, wr_en,
		output rdata
	);

endinterface

// File: design/spi_receiver.sv
`include "spi_reg_settings.svh"

module spi_receiver
	import spi_reg_pkg::*;
	(
	input  logic   clk,
	input  logic   cs,
	input  logic   sclk,	// Asynchronous SPI clock pin
	input  logic   mosi,	// Asynchronous SPI data pin
	spi_link_if.rx link
);

	logic [`SPI_SYNC_STAGES-1:0] sclk_sync;
	logic [`SPI_SYNC_STAGES-1:0] mosi_sync;
	logic                        sclk_s;	// Synchronized SCLK
	logic                        sclk_prev;	// Edge detect flop
	logic                        mosi_s;	// Aligned with sclk_prev
	logic [7:0]                  shift_reg;
	logic [2:0]                  bit_cnt;
	spi_byte_u                   next_byte;
	spi_byte_u                   byte_hold;

	assign sclk_s = sclk_sync[`SPI_SYNC_STAGES-1];

	// Both pins go through the same chain so MOSI keeps its place relative to SCLK.
	// SCLK idles low in mode 1, which is also the reset value.
	always_ff @(posedge clk or posedge cs) begin
		if (cs) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			sclk_prev <= 1'b0;
			mosi_s    <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-2:0], sclk};
			mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], mosi};
			sclk_prev <= sclk_s;
			mosi_s    <= mosi_sync[`SPI_SYNC_STAGES-1];
		end
	end

	assign link.sclk_rise = sclk_s & ~sclk_prev;
	assign link.sclk_fall = ~sclk_s & sclk_prev;

	// Mode 1: data is taken on the falling edge
	always_ff @(posedge clk or posedge cs) begin
		if (cs) begin
			shift_reg <= '0;
			bit_cnt   <= '0;
		end else if (link.sclk_fall) begin
			shift_reg <= {shift_reg[6:0], mosi_s};
			bit_cnt   <= bit_cnt + 3'd1;	// Wraps after eight bits
		end
	end

	// Eighth bit of the byte arrives now
	assign link.byte_done = link.sclk_fall && (bit_cnt == 3'd7);
	assign next_byte      = {shift_reg[6:0], mosi_s};

	// Completed byte stays readable until the next one finishes
	always_ff @(posedge clk) begin
		if (link.byte_done) begin
			byte_hold <= next_byte;
		end
	end

	// Bypass so the byte is valid in the byte_done cycle itself
	assign link.rx_byte = link.byte_done ? next_byte : byte_hold;

endmodule

// File: design/spi_transfer_ctrl.sv
module spi_transfer_ctrl
	import spi_reg_pkg::*;
	(
	input  logic       clk,
	input  logic       cs,
	spi_link_if.ctrl   link,
	reg_bus_if.master  bus,
	output logic       miso
);

	frame_state_e state;
	logic [2:0]   bit_idx;	// Bit of rdata on MISO during a read
	logic         cmd_seen;	// Command byte complete, waiting for the decode edge
	logic         written;	// Write already issued in this frame
	logic         wr_pulse;
	logic         decode;
	logic         wr_capture;

	// Decode on the rising edge that opens the second byte
	assign decode = (state == st_idle) && cmd_seen && link.sclk_rise;

	// Second byte_done of a write frame, taken once only
	assign wr_capture = (state == st_write) && link.byte_done && !written;

	always_ff @(posedge clk or posedge cs) begin
		if (cs) begin
			state    <= st_idle;
			bit_idx  <= '0;
			cmd_seen <= 1'b0;
			written  <= 1'b0;
			wr_pulse <= 1'b0;
		end else begin
			wr_pulse <= wr_capture;	// Strobe lands one cycle after byte_done
			case (state)
				st_idle: begin
					if (link.byte_done) begin
						cmd_seen <= 1'b1;
					end
					if (decode) begin
						cmd_seen <= 1'b0;
						bit_idx  <= 3'd7;	// MSB first
						if (link.rx_byte.cmd.rw) begin
							state <= st_read;
						end else begin
							state <= st_write;
						end
					end
				end
				st_read: begin
					if (link.sclk_rise) begin
						if (bit_idx == 3'd0) begin
							state <= st_idle;	// Last bit has been on the line
						end else begin
							bit_idx <= bit_idx - 3'd1;
						end
					end
				end
				st_write: begin
					// Stays here until cs ends the frame
					if (wr_capture) begin
						written <= 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Address and data words are plain payload
	always_ff @(posedge clk) begin
		if (decode) begin
			bus.addr <= link.rx_byte.cmd.addr;
		end
		if (wr_capture) begin
			bus.wdata <= link.rx_byte.data;
		end
	end

	assign bus.wr_en = wr_pulse;

	// MISO is held low outside a read
	always_comb begin
		if (state == st_read) begin
			miso = bus.rdata[bit_idx];
		end else begin
			miso = 1'b0;
		end
	end

endmodule

// File: design/reg_bank.sv
`include "spi_reg_settings.svh"

module reg_bank (
	input  logic     clk,
	reg_bus_if.slave bus
);

	// Storage only, contents survive from one frame to the next
	logic [7:0] regs [`SPI_REG_COUNT];

	// Single write port
	always_ff @(posedge clk) begin
		if (bus.wr_en) begin
			regs[bus.addr] <= bus.wdata;
		end
	end

	// Asynchronous read, the controller picks the bit it needs
	assign bus.rdata = regs[bus.addr];

endmodule

// File: design/spi_reg_top.sv
module spi_reg_top (
	input  logic clk,	// System clock, well above SCLK
	input  logic cs,	// Chip select, high ends the frame and resets
	input  logic sclk,
	input  logic mosi,
	output logic miso
);

	// Receiver to controller
	spi_link_if link ();

	// Controller to register bank
	reg_bus_if  bus ();

	spi_receiver u_receiver (
		.clk  (clk),
		.cs   (cs),
		.sclk (sclk),
		.mosi (mosi),
		.link (link.rx)
	);

	spi_transfer_ctrl u_ctrl (
		.clk  (clk),
		.cs   (cs),
		.link (link.ctrl),
		.bus  (bus.master),
		.miso (miso)
	);

	reg_bank u_bank (
		.clk (clk),
		.bus (bus.slave)
	);

endmodule

// File: verification/spi_reg_sva.sv
module spi_reg_sva
	import spi_reg_pkg::*;
	(
	input logic         clk,
	input logic         cs,
	input frame_state_e state,
	input logic         miso,
	input logic         wr_en	// Register write strobe of the controller
);

	// MISO must stay quiet unless a read is shifting out
	idle_miso_low: assert property (@(posedge clk) disable iff (cs)
		(state == st_idle) |-> !miso)
		else $error("miso driven high while the frame FSM is idle");

	// The strobe belongs to the data phase of a write frame
	wr_en_in_write: assert property (@(posedge clk) disable iff (cs)
		wr_en |-> (state == st_write))
		else $error("wr_en high outside the write state");

	wr_en_single: assert property (@(posedge clk) disable iff (cs)
		wr_en |=> !wr_en)
		else $error("wr_en high for two cycles in a row");

	// A deselected peripheral never writes
	no_wr_when_deselected: assert property (@(posedge clk)
		cs |-> !wr_en)
		else $error("wr_en high while cs is high");

endmodule

// File: verification/spi_reg_tb.sv
`include "spi_reg_settings.svh"

module spi_reg_tb;

	localparam int HALF       = 6;	// SCLK half period in clk cycles
	localparam int WAIT_LIMIT = 40;
	localparam int NUM_RANDOM = 40;

	logic clk;
	logic cs;
	logic sclk;
	logic mosi;
	logic miso;

	integer                    seed;
	logic [7:0]                model [`SPI_REG_COUNT];	// Expected register contents
	logic [`SPI_ADDR_BITS-1:0] rd_addr_q [$];	// Addresses of finished reads
	logic [7:0]                rd_data_q [$];	// Bytes seen on MISO

	spi_reg_top UUT (
		.clk  (clk),
		.cs   (cs),
		.sclk (sclk),
		.mosi (mosi),
		.miso (miso)
	);

	bind spi_transfer_ctrl spi_reg_sva u_sva (
		.clk   (clk),
		.cs    (cs),
		.state (state),
		.miso  (miso),
		.wr_en (wr_pulse)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Expected read value of one register
	function automatic logic [7:0] ref_read(input logic [`SPI_ADDR_BITS-1:0] addr);
		return model[addr];
	endfunction

	// Only the low command bits select the register
	function automatic void model_write(input logic [7:0] cmd, input logic [7:0] data);
		model[cmd[`SPI_ADDR_BITS-1:0]] = data;
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected 0x%02h got 0x%02h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s", what);
		$display("Something failed");
		$fatal(1, "Wait limit reached");
	endtask

	// Mode 1 master, returns the second byte seen on MISO
	task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] data,
		input int nbits, output logic [7:0] rx);
		logic [15:0] shift_out;
		shift_out = {cmd, data};
		rx        = 8'h00;
		@(posedge clk);
		cs <= 1'b0;
		repeat (HALF) @(posedge clk);
		for (int i = 0; i < nbits; i++) begin
			sclk <= 1'b1;
			mosi <= shift_out[15];	// Data changes with the rising edge
			shift_out = shift_out << 1;
			repeat (HALF - 1) @(posedge clk);
			@(negedge clk);
			if (i >= 8) begin
				rx = {rx[6:0], miso};	// Just before the falling edge
			end
			@(posedge clk);
			sclk <= 1'b0;
			if (i < nbits - 1) begin
				repeat (HALF) @(posedge clk);
			end
		end
	endtask

	task automatic end_frame();
		repeat (HALF) @(posedge clk);
		cs <= 1'b1;
		repeat (HALF) @(posedge clk);
	endtask

	task automatic wait_for_write();
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			seen = UUT.u_ctrl.wr_pulse;
			cycles++;
		end
		if (!seen) begin
			timeout_fail("the register write strobe");
		end
	endtask

	task automatic write_frame(input logic [7:0] cmd, input logic [7:0] data);
		logic [7:0] unused_rx;
		spi_frame({1'b0, cmd[6:0]}, data, 16, unused_rx);
		wait_for_write();
		model_write(cmd, data);
		end_frame();
	endtask

	task automatic read_frame(input logic [7:0] cmd);
		logic [7:0] rx;
		spi_frame({1'b1, cmd[6:0]}, 8'h00, 16, rx);
		rd_addr_q.push_back(cmd[`SPI_ADDR_BITS-1:0]);
		rd_data_q.push_back(rx);
		end_frame();
	endtask

	// Write cut short by cs, the model keeps its old value
	task automatic abort_frame(input logic [7:0] cmd, input logic [7:0] data);
		logic [7:0] unused_rx;
		spi_frame({1'b0, cmd[6:0]}, data, 12, unused_rx);
		end_frame();
	endtask

	task automatic check_idle_miso();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check_value("miso", 8'h00, {7'b0, miso});
		end
	endtask

	task automatic wait_reads_checked();
		int cycles;
		cycles = 0;
		while (rd_addr_q.size() > 0 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (rd_addr_q.size() > 0) begin
			timeout_fail("the pending read comparisons");
		end
	endtask

	// Compares each finished read against the model
	always @(negedge clk) begin : compare_reads
		logic [`SPI_ADDR_BITS-1:0] addr;
		logic [7:0]                got;
		if (rd_addr_q.size() > 0) begin
			addr = rd_addr_q.pop_front();
			got  = rd_data_q.pop_front();
			check_value("miso_byte", ref_read(addr), got);
		end
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [7:0]  wval;
		logic [7:0]  held;
		seed = 8;
		cs   = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		repeat (2) @(posedge clk);
		cs <= 1'b0;

		// Selected but no SCLK
		check_idle_miso();
		end_frame();

		for (int i = 0; i < `SPI_REG_COUNT; i++) begin
			wval = 8'h5a + 8'h13 * 8'(i);
			write_frame(8'(i), wval);
		end
		for (int i = 0; i < `SPI_REG_COUNT; i++) begin
			read_frame(8'(i));
		end

		repeat (NUM_RANDOM) begin
			rnd = $random(seed);
			if (rnd[16]) begin
				read_frame(rnd[7:0]);
			end else begin
				write_frame(rnd[7:0], rnd[15:8]);
			end
		end

		write_frame(8'h22, 8'hc3);	// Bit 5 set, address 2
		read_frame(8'h02);

		held = ref_read(`SPI_ADDR_BITS'(5));
		abort_frame(8'h05, ~held);
		read_frame(8'h05);

		wait_reads_checked();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/spi_reg_pkg.sv
design/spi_link_if.sv
design/reg_bus_if.sv
design/spi_receiver.sv
design/spi_transfer_ctrl.sv
design/reg_bank.sv
design/spi_reg_top.sv
verification/spi_reg_sva.sv
verification/spi_reg_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = spi_reg_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

SOURCES = $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status is nonzero when the testbench stops with $$fatal
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
